// ==== hdl/cpu_types_pkg.sv ====
package cpu_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Width constants.
	////////////////////////////////////////////////////////////////////////////

	// Data path width.
	parameter int WORD_W = 32;
	// Register number width.
	parameter int REG_W = 5;
	// ALU opcode width.
	parameter int OPCODE_W = 4;
	// Shift amount width, low bits of portb.
	parameter int SHAMT_W = 5;

	////////////////////////////////////////////////////////////////////////////
	// Types.
	////////////////////////////////////////////////////////////////////////////

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0] regbits_t;

	// ALU opcodes.
	typedef enum logic [OPCODE_W-1:0] {
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_AND  = 4'h2,
		ALU_OR   = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_NOR  = 4'h5,
		ALU_SLT  = 4'h6,
		ALU_SLTU = 4'h7,
		ALU_SLL  = 4'h8,
		ALU_SRL  = 4'h9
	} aluop_t;

endpackage

// ==== hdl/data_path_muxs_pkg.sv ====
package data_path_muxs_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path mux selects.
	////////////////////////////////////////////////////////////////////////////

	// Destination register number for write back.
	typedef enum logic {
		SEL_RD = 1'b0,
		SEL_RT = 1'b1
	} reg_dest_mux_selection;

	// Source of the write back value.
	typedef enum logic {
		SEL_RESULT = 1'b0,
		SEL_LOAD   = 1'b1
	} wb_src_mux_selection;

endpackage

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu
	import cpu_types_pkg::*;
(
	input  aluop_t alu_op,
	input  word_t  porta,
	input  word_t  portb,
	output word_t  result,
	output logic   zero,
	output logic   overflow
);

	////////////////////////////////////////////////////////////////////////////
	// Local signals.
	////////////////////////////////////////////////////////////////////////////

	// Shift amount.
	logic [SHAMT_W-1:0] shamt;
	// Sign bits of operands and result.
	logic sign_a, sign_b, sign_r;

	assign shamt  = portb[SHAMT_W-1:0];
	assign sign_a = porta[WORD_W-1];
	assign sign_b = portb[WORD_W-1];
	assign sign_r = result[WORD_W-1];

	////////////////////////////////////////////////////////////////////////////
	// Function select.
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Unknown opcodes give zero.
		result = '0;
		case (alu_op)
			ALU_ADD:  result = porta + portb;
			ALU_SUB:  result = porta - portb;
			ALU_AND:  result = porta & portb;
			ALU_OR:   result = porta | portb;
			ALU_XOR:  result = porta ^ portb;
			ALU_NOR:  result = ~(porta | portb);
			// Signed compare.
			ALU_SLT:  result = word_t'($signed(porta) < $signed(portb));
			// Unsigned compare.
			ALU_SLTU: result = word_t'(porta < portb);
			// Logical shifts of porta.
			ALU_SLL:  result = porta << shamt;
			ALU_SRL:  result = porta >> shamt;
			default:  result = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Flags.
	////////////////////////////////////////////////////////////////////////////

	assign zero = (result == '0);

	always_comb begin
		overflow = 1'b0;
		// Same-sign add flipping sign.
		if (alu_op == ALU_ADD)
			overflow = (sign_a == sign_b) && (sign_r != sign_a);
		// Opposite-sign sub flipping sign.
		else if (alu_op == ALU_SUB)
			overflow = (sign_a != sign_b) && (sign_r != sign_a);
	end

endmodule

// ==== hdl/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;
(
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  iREN_ID_EX,
	input  logic                  dREN_ID_EX,
	input  logic                  dWEN_ID_EX,
	input  logic                  halt_ID_EX,
	input  logic                  WEN_ID_EX,
	input  reg_dest_mux_selection reg_dest_ID_EX,
	input  regbits_t              Rt_ID_EX,
	input  regbits_t              Rd_ID_EX,
	input  word_t                 result,
	input  word_t                 rdat2,
	output logic                  imemREN_EX_MEM,
	output logic                  dmemREN_EX_MEM,
	output logic                  dmemWEN_EX_MEM,
	output logic                  WEN_EX_MEM,
	output logic                  halt_EX_MEM,
	output reg_dest_mux_selection reg_dest_EX_MEM,
	output regbits_t              Rt_EX_MEM,
	output regbits_t              Rd_EX_MEM,
	output word_t                 dmemaddr_EX_MEM,
	output word_t                 dmemstore_EX_MEM,
	output word_t                 result_EX_MEM
);

	// Latched control bits.
	logic iren_reg, iren_nxt;
	logic dren_reg, dren_nxt;
	logic dwen_reg, dwen_nxt;
	logic halt_reg, halt_nxt;
	logic wen_reg, wen_nxt;
	reg_dest_mux_selection reg_dest_reg, reg_dest_nxt;
	// Latched register numbers.
	regbits_t rt_reg, rt_nxt;
	regbits_t rd_reg, rd_nxt;
	// Latched data words.
	word_t result_reg, result_nxt;
	word_t rdat2_reg, rdat2_nxt;

	////////////////////////////////////////////////////////////////////////////
	// Outputs.
	////////////////////////////////////////////////////////////////////////////

	assign imemREN_EX_MEM   = iren_reg;
	assign dmemREN_EX_MEM   = dren_reg;
	assign dmemWEN_EX_MEM   = dwen_reg;
	assign WEN_EX_MEM       = wen_reg;
	assign halt_EX_MEM      = halt_reg;
	assign reg_dest_EX_MEM  = reg_dest_reg;
	assign Rt_EX_MEM        = rt_reg;
	assign Rd_EX_MEM        = rd_reg;
	// Address and result share one latched word.
	assign dmemaddr_EX_MEM  = result_reg;
	assign result_EX_MEM    = result_reg;
	assign dmemstore_EX_MEM = rdat2_reg;

	////////////////////////////////////////////////////////////////////////////
	// Next state and registers.
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Advance every cycle, no stall.
		iren_nxt     = iREN_ID_EX;
		dren_nxt     = dREN_ID_EX;
		dwen_nxt     = dWEN_ID_EX;
		halt_nxt     = halt_ID_EX;
		wen_nxt      = WEN_ID_EX;
		reg_dest_nxt = reg_dest_ID_EX;
		rt_nxt       = Rt_ID_EX;
		rd_nxt       = Rd_ID_EX;
		result_nxt   = result;
		rdat2_nxt    = rdat2;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// Fetch stays enabled in reset.
			iren_reg     <= 1'b1;
			dren_reg     <= 1'b0;
			dwen_reg     <= 1'b0;
			halt_reg     <= 1'b0;
			wen_reg      <= 1'b0;
			reg_dest_reg <= SEL_RD;
			rt_reg       <= '0;
			rd_reg       <= '0;
			result_reg   <= '0;
			rdat2_reg    <= '0;
		end else begin
			iren_reg     <= iren_nxt;
			dren_reg     <= dren_nxt;
			dwen_reg     <= dwen_nxt;
			halt_reg     <= halt_nxt;
			wen_reg      <= wen_nxt;
			reg_dest_reg <= reg_dest_nxt;
			rt_reg       <= rt_nxt;
			rd_reg       <= rd_nxt;
			result_reg   <= result_nxt;
			rdat2_reg    <= rdat2_nxt;
		end
	end

	// Memory stage never sees load and store together.
	a_no_rd_wr: assert property (@(posedge CLK) disable iff (!nRST)
		!(dren_reg && dwen_reg));

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram
	import cpu_types_pkg::*;
#(
	parameter int RAM_WORDS = 256
) (
	input  logic  CLK,
	input  logic  nRST,
	input  logic  dmemREN,
	input  logic  dmemWEN,
	input  word_t dmemaddr,
	input  word_t dmemstore,
	output word_t dmemload
);

	// Word index width.
	localparam int IDX_W = $clog2(RAM_WORDS);

	// Storage array.
	word_t mem [RAM_WORDS];
	// Word index from byte address.
	logic [IDX_W-1:0] idx;

	assign idx = dmemaddr[IDX_W+1:2];

	////////////////////////////////////////////////////////////////////////////
	// Write port.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// Clear whole array.
			for (int i = 0; i < RAM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (dmemWEN) begin
			mem[idx] <= dmemstore;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port.
	////////////////////////////////////////////////////////////////////////////

	// Combinational read, zero when idle.
	assign dmemload = dmemREN ? mem[idx] : '0;

	// Word accesses only.
	a_aligned: assert property (@(posedge CLK) disable iff (!nRST)
		(dmemREN || dmemWEN) |-> (dmemaddr[1:0] == 2'b00));

endmodule

// ==== hdl/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;
(
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  WEN_EX_MEM,
	input  logic                  halt_EX_MEM,
	input  logic                  dmemREN_EX_MEM,
	input  reg_dest_mux_selection reg_dest_EX_MEM,
	input  regbits_t              Rt_EX_MEM,
	input  regbits_t              Rd_EX_MEM,
	input  word_t                 result_EX_MEM,
	input  word_t                 dmemload,
	output logic                  WEN_MEM_WB,
	output logic                  halt_MEM_WB,
	output regbits_t              wsel,
	output word_t                 wdat
);

	// Write back source select.
	wb_src_mux_selection wb_src;
	// Selected register number and data.
	regbits_t wsel_nxt;
	word_t wdat_nxt;

	////////////////////////////////////////////////////////////////////////////
	// Write back muxes.
	////////////////////////////////////////////////////////////////////////////

	// Loads write memory data.
	assign wb_src = dmemREN_EX_MEM ? SEL_LOAD : SEL_RESULT;

	always_comb begin
		// Rd for R-type, Rt for immediates and loads.
		case (reg_dest_EX_MEM)
			SEL_RT:  wsel_nxt = Rt_EX_MEM;
			default: wsel_nxt = Rd_EX_MEM;
		endcase
		case (wb_src)
			SEL_LOAD: wdat_nxt = dmemload;
			default:  wdat_nxt = result_EX_MEM;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Registers.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			WEN_MEM_WB  <= 1'b0;
			halt_MEM_WB <= 1'b0;
			wsel        <= '0;
			wdat        <= '0;
		end else begin
			WEN_MEM_WB  <= WEN_EX_MEM;
			halt_MEM_WB <= halt_EX_MEM;
			wsel        <= wsel_nxt;
			wdat        <= wdat_nxt;
		end
	end

	// Register zero is never a write target.
	a_no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
		WEN_MEM_WB |-> (wsel != '0));

endmodule

// ==== hdl/ex_mem_slice.sv ====
`timescale 1ns/1ps

module ex_mem_slice
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;
#(
	parameter int RAM_WORDS = 256
) (
	input  logic                  CLK,
	input  logic                  nRST,
	input  aluop_t                alu_op,
	input  word_t                 porta,
	input  word_t                 portb,
	input  word_t                 rdat2,
	input  regbits_t              Rt_ID_EX,
	input  regbits_t              Rd_ID_EX,
	input  reg_dest_mux_selection reg_dest_ID_EX,
	input  logic                  WEN_ID_EX,
	input  logic                  dREN_ID_EX,
	input  logic                  dWEN_ID_EX,
	input  logic                  iREN_ID_EX,
	input  logic                  halt_ID_EX,
	output regbits_t              wsel,
	output word_t                 wdat,
	output logic                  WEN_MEM_WB,
	output logic                  halt_MEM_WB,
	output logic                  imemREN_EX_MEM,
	output logic                  zero,
	output logic                  overflow
);

	////////////////////////////////////////////////////////////////////////////
	// Stage wires.
	////////////////////////////////////////////////////////////////////////////

	// Execute stage.
	word_t result;
	// EX/MEM outputs.
	logic dmemREN_EX_MEM, dmemWEN_EX_MEM, WEN_EX_MEM, halt_EX_MEM;
	reg_dest_mux_selection reg_dest_EX_MEM;
	regbits_t Rt_EX_MEM, Rd_EX_MEM;
	word_t dmemaddr_EX_MEM, dmemstore_EX_MEM, result_EX_MEM;
	// Memory read data.
	word_t dmemload;

	////////////////////////////////////////////////////////////////////////////
	// Blocks.
	////////////////////////////////////////////////////////////////////////////

	alu alu_i (.alu_op, .porta, .portb, .result, .zero, .overflow);

	ex_mem_reg ex_mem_reg_i (
		.CLK, .nRST,
		.iREN_ID_EX, .dREN_ID_EX, .dWEN_ID_EX, .halt_ID_EX, .WEN_ID_EX,
		.reg_dest_ID_EX, .Rt_ID_EX, .Rd_ID_EX, .result, .rdat2,
		.imemREN_EX_MEM, .dmemREN_EX_MEM, .dmemWEN_EX_MEM, .WEN_EX_MEM,
		.halt_EX_MEM, .reg_dest_EX_MEM, .Rt_EX_MEM, .Rd_EX_MEM,
		.dmemaddr_EX_MEM, .dmemstore_EX_MEM, .result_EX_MEM
	);

	data_ram #(.RAM_WORDS(RAM_WORDS)) data_ram_i (
		.CLK, .nRST,
		.dmemREN(dmemREN_EX_MEM), .dmemWEN(dmemWEN_EX_MEM),
		.dmemaddr(dmemaddr_EX_MEM), .dmemstore(dmemstore_EX_MEM), .dmemload
	);

	mem_wb_reg mem_wb_reg_i (
		.CLK, .nRST,
		.WEN_EX_MEM, .halt_EX_MEM, .dmemREN_EX_MEM, .reg_dest_EX_MEM,
		.Rt_EX_MEM, .Rd_EX_MEM, .result_EX_MEM, .dmemload,
		.WEN_MEM_WB, .halt_MEM_WB, .wsel, .wdat
	);

endmodule

// ==== testbench/ex_mem_slice_tb.sv ====
`timescale 1ns/1ps

module ex_mem_slice_tb
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;
;

	localparam int RAM_WORDS = 256;
	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int MAX_ROWS = 64;
	localparam int RST_CYCLES = 16;

	// DUT ports.
	logic CLK = 1'b0;
	logic nRST;
	aluop_t alu_op;
	word_t porta, portb, rdat2;
	regbits_t Rt_ID_EX, Rd_ID_EX;
	reg_dest_mux_selection reg_dest_ID_EX;
	logic WEN_ID_EX, dREN_ID_EX, dWEN_ID_EX, iREN_ID_EX, halt_ID_EX;
	regbits_t wsel;
	word_t wdat;
	logic WEN_MEM_WB, halt_MEM_WB, imemREN_EX_MEM, zero, overflow;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table and expected values.
	////////////////////////////////////////////////////////////////////////////

	aluop_t op_tab [MAX_ROWS];
	word_t a_tab [MAX_ROWS];
	word_t b_tab [MAX_ROWS];
	word_t st_tab [MAX_ROWS];
	regbits_t rt_tab [MAX_ROWS];
	regbits_t rd_tab [MAX_ROWS];
	reg_dest_mux_selection dst_tab [MAX_ROWS];
	logic wen_tab [MAX_ROWS];
	logic dren_tab [MAX_ROWS];
	logic dwen_tab [MAX_ROWS];
	logic iren_tab [MAX_ROWS];
	logic halt_tab [MAX_ROWS];
	// Model outputs per row.
	word_t exp_wdat [MAX_ROWS];
	regbits_t exp_wsel [MAX_ROWS];
	logic exp_zero [MAX_ROWS];
	logic exp_ovf [MAX_ROWS];
	// Shadow copy of the data RAM.
	word_t shadow [RAM_WORDS];

	int n_rows = 0;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = RST_CYCLES + MAX_ROWS + 10;

	ex_mem_slice #(.RAM_WORDS(RAM_WORDS)) dut_i (
		.CLK, .nRST, .alu_op, .porta, .portb, .rdat2, .Rt_ID_EX, .Rd_ID_EX,
		.reg_dest_ID_EX, .WEN_ID_EX, .dREN_ID_EX, .dWEN_ID_EX, .iREN_ID_EX,
		.halt_ID_EX, .wsel, .wdat, .WEN_MEM_WB, .halt_MEM_WB, .imemREN_EX_MEM,
		.zero, .overflow
	);

	always #50 CLK = ~CLK;

	// Run limit.
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model.
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t model_alu(input aluop_t op, input word_t a, input word_t b);
		word_t r;
		r = 32'h0;
		case (op)
			ALU_ADD:  r = a + b;
			ALU_SUB:  r = a + ~b + 32'h1;
			ALU_AND:  r = a & b;
			ALU_OR:   r = a | b;
			ALU_XOR:  r = a ^ b;
			ALU_NOR:  r = ~a & ~b;
			// Differing signs decide directly.
			ALU_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			ALU_SLTU: r = {31'b0, a < b};
			ALU_SLL:  r = a << b[4:0];
			ALU_SRL:  r = a >> b[4:0];
			default:  r = 32'h0;
		endcase
		return r;
	endfunction

	// Signed overflow from a 33 bit sum.
	function automatic logic model_ovf(input aluop_t op, input word_t a, input word_t b);
		logic signed [32:0] wide;
		wide = 33'sd0;
		if (op == ALU_ADD)
			wide = $signed({a[31], a}) + $signed({b[31], b});
		else if (op == ALU_SUB)
			wide = $signed({a[31], a}) - $signed({b[31], b});
		return wide[32] != wide[31];
	endfunction

	// Append one row and run it through the model in issue order.
	task automatic add_row(input aluop_t op, input word_t a, input word_t b,
		input word_t st, input regbits_t rt, input regbits_t rd,
		input reg_dest_mux_selection dst, input logic wen, input logic dren,
		input logic dwen, input logic iren, input logic halt);
		word_t res;
		int idx;
		res = model_alu(op, a, b);
		idx = res[IDX_W+1:2];
		op_tab[n_rows] = op;
		a_tab[n_rows] = a;
		b_tab[n_rows] = b;
		st_tab[n_rows] = st;
		rt_tab[n_rows] = rt;
		rd_tab[n_rows] = rd;
		dst_tab[n_rows] = dst;
		wen_tab[n_rows] = wen;
		dren_tab[n_rows] = dren;
		dwen_tab[n_rows] = dwen;
		iren_tab[n_rows] = iren;
		halt_tab[n_rows] = halt;
		exp_zero[n_rows] = (res == 32'h0);
		exp_ovf[n_rows] = model_ovf(op, a, b);
		exp_wsel[n_rows] = (dst == SEL_RT) ? rt : rd;
		exp_wdat[n_rows] = dren ? shadow[idx] : res;
		if (dwen)
			shadow[idx] = st;
		n_rows++;
	endtask

	task automatic add_alu(input aluop_t op, input word_t a, input word_t b,
		input reg_dest_mux_selection dst);
		add_row(op, a, b, $urandom, 5'd9, 5'd17, dst, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic add_store(input word_t addr, input word_t data);
		add_row(ALU_ADD, addr, 32'h0, data, 5'd1, 5'd2, SEL_RD, 1'b0, 1'b0, 1'b1, 1'b1,
			1'b0);
	endtask

	task automatic add_load(input word_t base, input word_t off, input regbits_t rt);
		add_row(ALU_ADD, base, off, $urandom, rt, 5'd30, SEL_RT, 1'b1, 1'b1, 1'b0, 1'b1,
			1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drive and compare.
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_row(input int j);
		alu_op = op_tab[j];
		porta = a_tab[j];
		portb = b_tab[j];
		rdat2 = st_tab[j];
		Rt_ID_EX = rt_tab[j];
		Rd_ID_EX = rd_tab[j];
		reg_dest_ID_EX = dst_tab[j];
		WEN_ID_EX = wen_tab[j];
		dREN_ID_EX = dren_tab[j];
		dWEN_ID_EX = dwen_tab[j];
		iREN_ID_EX = iren_tab[j];
		halt_ID_EX = halt_tab[j];
	endtask

	// Bubble with fetch enabled.
	task automatic drive_idle();
		alu_op = ALU_ADD;
		porta = 32'h0;
		portb = 32'h0;
		rdat2 = 32'h0;
		Rt_ID_EX = 5'd0;
		Rd_ID_EX = 5'd0;
		reg_dest_ID_EX = SEL_RD;
		WEN_ID_EX = 1'b0;
		dREN_ID_EX = 1'b0;
		dWEN_ID_EX = 1'b0;
		iREN_ID_EX = 1'b1;
		halt_ID_EX = 1'b0;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_reset_outputs();
		compare_value("imemREN_EX_MEM", imemREN_EX_MEM, 32'h1);
		compare_value("WEN_MEM_WB", WEN_MEM_WB, 32'h0);
		compare_value("halt_MEM_WB", halt_MEM_WB, 32'h0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence.
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int seed_ret;
		aluop_t op;
		nRST = 1'b0;
		drive_idle();
		seed_ret = $urandom(32'hf0f1_076c);
		for (int i = 0; i < RAM_WORDS; i++) begin
			shadow[i] = 32'h0;
		end

		// Edge cases for flags, compares and shifts.
		add_alu(ALU_ADD, 32'h7fff_ffff, 32'h0000_0001, SEL_RD);
		add_alu(ALU_ADD, 32'h8000_0000, 32'h8000_0000, SEL_RT);
		add_alu(ALU_ADD, 32'h7fff_ffff, 32'h0000_0000, SEL_RD);
		add_alu(ALU_SUB, 32'h8000_0000, 32'h0000_0001, SEL_RD);
		add_alu(ALU_SUB, 32'h7fff_ffff, 32'hffff_ffff, SEL_RT);
		add_alu(ALU_SUB, 32'h1234_5678, 32'h1234_5678, SEL_RD);
		add_alu(ALU_SLT, 32'hffff_ffff, 32'h0000_0001, SEL_RD);
		add_alu(ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, SEL_RT);
		add_alu(ALU_SLL, 32'h0000_0001, 32'h0000_001f, SEL_RD);
		add_alu(ALU_SRL, 32'h8000_0000, 32'hffff_ffff, SEL_RT);
		add_alu(ALU_NOR, 32'h0000_0000, 32'h0000_0000, SEL_RD);
		add_alu(ALU_AND, 32'hffff_ffff, 32'h0000_0000, SEL_RT);

		// Random operands, two rows per opcode.
		for (int k = 0; k < 20; k++) begin
			op = aluop_t'(k % 10);
			add_row(op, $urandom, $urandom, $urandom, 5'(1 + $urandom % 31),
				5'(1 + $urandom % 31), reg_dest_mux_selection'($urandom % 2),
				1'($urandom % 2), 1'b0, 1'b0, 1'(($urandom % 4) != 0), 1'b0);
		end

		// Stores and loads, back to back on one address.
		add_store(32'h0000_0010, $urandom);
		add_load(32'h0000_0008, 32'h0000_0008, 5'd3);
		add_store(32'h0000_0040, $urandom);
		add_store(32'h0000_0044, $urandom);
		add_alu(ALU_OR, $urandom, $urandom, SEL_RD);
		add_load(32'h0000_0044, 32'h0000_0000, 5'd4);
		add_load(32'h0000_0040, 32'h0000_0000, 5'd5);
		// Never written.
		add_load(32'h0000_0080, 32'h0000_0000, 5'd6);
		add_store(32'h0000_03fc, $urandom);
		add_load(32'h0000_03f0, 32'h0000_000c, 5'd7);

		// Halt with fetch stopped.
		add_row(ALU_ADD, 32'h0, 32'h0, 32'h0, 5'd1, 5'd2, SEL_RD, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b1);
		cycle_limit = RST_CYCLES + n_rows + 10;

		// Reset phase.
		repeat (RST_CYCLES) begin
			@(posedge CLK);
			#1;
			check_reset_outputs();
		end
		nRST = 1'b1;

		// One row per cycle, results two rows behind.
		for (int j = 0; j < n_rows + 2; j++) begin
			@(posedge CLK);
			#1;
			if (j < n_rows)
				drive_row(j);
			else
				drive_idle();
			#40;
			if (j < n_rows) begin
				compare_value("zero", zero, exp_zero[j]);
				compare_value("overflow", overflow, exp_ovf[j]);
			end
			// Reset and trailing bubbles keep fetch enabled.
			if (j >= 1 && j <= n_rows)
				compare_value("imemREN_EX_MEM", imemREN_EX_MEM, iren_tab[j-1]);
			else
				compare_value("imemREN_EX_MEM", imemREN_EX_MEM, 32'h1);
			if (j >= 2) begin
				compare_value("wdat", wdat, exp_wdat[j-2]);
				compare_value("wsel", wsel, exp_wsel[j-2]);
				compare_value("WEN_MEM_WB", WEN_MEM_WB, wen_tab[j-2]);
				compare_value("halt_MEM_WB", halt_MEM_WB, halt_tab[j-2]);
			end else begin
				// Pipeline still holds reset bubbles.
				compare_value("WEN_MEM_WB", WEN_MEM_WB, 32'h0);
				compare_value("halt_MEM_WB", halt_MEM_WB, 32'h0);
			end
		end

		$display("rows applied %0d, errors %0d", n_rows, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== ex_mem_slice.f ====
hdl/cpu_types_pkg.sv
hdl/data_path_muxs_pkg.sv
hdl/alu.sv
hdl/ex_mem_reg.sv
hdl/data_ram.sv
hdl/mem_wb_reg.sv
hdl/ex_mem_slice.sv
testbench/ex_mem_slice_tb.sv

// ==== Bender.yml ====
package:
  name: ex_mem_slice

sources:
  - hdl/cpu_types_pkg.sv
  - hdl/data_path_muxs_pkg.sv
  - hdl/alu.sv
  - hdl/ex_mem_reg.sv
  - hdl/data_ram.sv
  - hdl/mem_wb_reg.sv
  - hdl/ex_mem_slice.sv
  - target: test
    files:
      - testbench/ex_mem_slice_tb.sv
